// File: tb.f
src/tage_pkg.sv
src/tage_hash.sv
src/tage_table.sv
src/tage_base.sv
src/tage_select.sv
src/tage_update.sv
src/tage_top.sv
tb/tage_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
TOP ?= tage_tb
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
PASS_MSG = Regression passed

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: tb/tage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tage_tb import tage_pkg::*; ();

	localparam int unsigned MAX_CYCLES = 3000;

	logic clk = 1'b0;
	logic rst;
	logic stall;
	logic lookup_valid;
	tage_req_t lookup_req;
	logic upd_valid;
	tage_upd_t upd;
	logic pred_valid;
	logic pred_taken;
	tage_meta_t pred_meta;

	logic [31:0] rng_state = 32'd73538;
	int unsigned cycles = 0;
	bit base_used [1 << BASE_IDX_W];
	bit idx_used [NBANK][1 << IDX_W];
	bctr_t base_model [1 << BASE_IDX_W];
	logic ent_valid [NBANK];
	ctr_t ent_ctr [NBANK];
	u_t ent_u [NBANK];
	tage_meta_t last_meta;
	ctr_t saved_ctr;
	u_t saved_u;
	pc_t pc;
	ghr_t g;
	ghr_t g2;
	logic [31:0] r;

	tage_top tage_top_inst (
		.clk(clk), .rst(rst), .stall(stall),
		.lookup_valid(lookup_valid), .lookup_req(lookup_req),
		.upd_valid(upd_valid), .upd(upd),
		.pred_valid(pred_valid), .pred_taken(pred_taken), .pred_meta(pred_meta)
	);

	always #5 clk = ~clk;

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
			else fail_now($sformatf("Mismatch at %0t: %s expected %h, actual %h",
				$time, name, exp, act));
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES) begin
			fail_now("Timeout, the tests did not finish in the cycle budget");
		end
	end

	a_latency: assert property (@(posedge clk) disable iff (!rst)
		(lookup_valid && !stall) |=> pred_valid)
		else fail_now($sformatf("Mismatch at %0t: pred_valid expected 1, actual %b",
			$time, $sampled(pred_valid)));
	a_no_spurious: assert property (@(posedge clk) disable iff (!rst)
		!(lookup_valid && !stall) |=> !pred_valid)
		else fail_now($sformatf("Mismatch at %0t: pred_valid expected 0, actual %b",
			$time, $sampled(pred_valid)));
	a_stall_hold: assert property (@(posedge clk) disable iff (!rst)
		stall |=> ($stable(pred_taken) && $stable(pred_meta)))
		else fail_now("prediction output changed while stalled");

	function automatic logic [31:0] next_rand();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	// hash model folding the history bit by bit into width slots
	function automatic logic [TAG_W-1:0] fold_hist(input ghr_t ghr, input int len, input int width);
		logic [TAG_W-1:0] res;
		res = '0;
		for (int i = 0; i < len; i++) begin
			res[i % width] ^= ghr[i];
		end
		return res;
	endfunction

	function automatic tidx_t model_idx(input pc_t p, input ghr_t ghr, input int b);
		return tidx_t'(fold_hist(ghr, 8 << b, IDX_W)) ^ p[IDX_W+1:2] ^ tidx_t'(b);
	endfunction

	function automatic tag_t model_tag(input pc_t p, input ghr_t ghr, input int b);
		return fold_hist(ghr, 8 << b, TAG_W) ^ p[TAG_W+1:2] ^ p[2*TAG_W+1:TAG_W+2];
	endfunction

	function automatic bidx_t base_index(input pc_t p);
		bidx_t res;
		for (int i = 0; i < BASE_IDX_W; i++) begin
			res[i] = p[i + 2] ^ p[PC_W - BASE_IDX_W + i];
		end
		return res;
	endfunction

	// zero tags would hit on untouched entries
	function automatic logic pair_ok(input pc_t p, input ghr_t ghr, input int want_idx0,
		input int avoid_tag);
		logic ok;
		ok = 1'b1;
		for (int b = 0; b < NBANK; b++) begin
			if (model_tag(p, ghr, b) == '0) begin
				ok = 1'b0;
			end
			if (b == 0 && want_idx0 >= 0) begin
				if (int'(model_idx(p, ghr, 0)) != want_idx0 ||
					int'(model_tag(p, ghr, 0)) == avoid_tag) begin
					ok = 1'b0;
				end
			end else if (idx_used[b][model_idx(p, ghr, b)]) begin
				ok = 1'b0;
			end
		end
		return ok;
	endfunction

	task automatic pick_pc(output pc_t p);
		p = next_rand() & ~32'h3;
		while (base_used[base_index(p)]) begin
			p = next_rand() & ~32'h3;
		end
		base_used[base_index(p)] = 1'b1;
	endtask

	task automatic new_pair(input pc_t p, input int want_idx0, input int avoid_tag,
		output ghr_t ghr);
		int tries;
		tries = 0;
		ghr = next_rand();
		while (!pair_ok(p, ghr, want_idx0, avoid_tag)) begin
			tries++;
			if (tries > 200000) begin
				fail_now("No usable history found for the chosen PC");
			end
			ghr = next_rand();
		end
		for (int b = 0; b < NBANK; b++) begin
			idx_used[b][model_idx(p, ghr, b)] = 1'b1;
			ent_valid[b] = 1'b0;
			ent_ctr[b] = '0;
			ent_u[b] = '0;
		end
	endtask

	function automatic int sat(input int v, input logic up, input int max);
		if (up) begin
			return (v < max) ? v + 1 : v;
		end
		return (v > 0) ? v - 1 : 0;
	endfunction

	// expected lookup result for the current pair
	function automatic tage_meta_t expect_meta(input bidx_t bi);
		tage_meta_t m;
		m = '0;
		m.base_ctr = base_model[bi];
		m.alt_taken = base_model[bi][1];
		m.pred_taken = m.alt_taken;
		for (int b = 0; b < NBANK; b++) begin
			m.ctrs[b] = ent_ctr[b];
			m.us[b] = ent_u[b];
			if (ent_valid[b]) begin
				m.provider = bank_mask_t'(1 << b);
				m.pred_taken = ent_ctr[b][CTR_W-1];
			end
		end
		return m;
	endfunction

	task automatic apply_update(input bidx_t bi, input tage_meta_t m, input logic taken);
		int prov;
		int tgt;
		prov = -1;
		tgt = -1;
		for (int b = 0; b < NBANK; b++) begin
			if (m.provider[b]) begin
				prov = b;
			end
		end
		if (prov < 0) begin
			base_model[bi] = bctr_t'(sat(int'(m.base_ctr), taken, 3));
		end else begin
			ent_ctr[prov] = ctr_t'(sat(int'(m.ctrs[prov]), taken, 7));
			if (m.pred_taken != m.alt_taken) begin
				ent_u[prov] = u_t'(sat(int'(m.us[prov]), m.pred_taken == taken, 3));
			end
		end
		if (m.pred_taken != taken) begin
			for (int b = prov + 1; b < NBANK; b++) begin
				if (tgt < 0 && m.us[b] == '0) begin
					tgt = b;
				end
			end
			if (tgt >= 0) begin
				ent_valid[tgt] = 1'b1;
				ent_ctr[tgt] = taken ? 3'b100 : 3'b011;
				ent_u[tgt] = '0;
			end else begin
				for (int b = prov + 1; b < NBANK; b++) begin
					ent_u[b] = u_t'(sat(int'(m.us[b]), 1'b0, 3));
				end
			end
		end
	endtask

	task automatic do_lookup(input pc_t p, input ghr_t ghr);
		@(posedge clk);
		stall <= 1'b0;
		lookup_valid <= 1'b1;
		lookup_req.pc <= p;
		lookup_req.ghr <= ghr;
		@(posedge clk);
		lookup_valid <= 1'b0;
		@(negedge clk);
		while (!pred_valid) begin
			@(negedge clk);
		end
	endtask

	task automatic lookup_check(input pc_t p, input ghr_t ghr);
		tage_meta_t exp;
		exp = expect_meta(base_index(p));
		do_lookup(p, ghr);
		check_eq("pred_meta", 32'(exp), 32'(pred_meta));
		check_eq("pred_taken", 32'(exp.pred_taken), 32'(pred_taken));
		last_meta = pred_meta;
	endtask

	// send back the last meta with the resolved outcome
	task automatic update_last(input pc_t p, input ghr_t ghr, input logic taken);
		@(posedge clk);
		upd_valid <= 1'b1;
		upd.req.pc <= p;
		upd.req.ghr <= ghr;
		upd.meta <= last_meta;
		upd.taken <= taken;
		@(posedge clk);
		upd_valid <= 1'b0;
		apply_update(base_index(p), last_meta, taken);
	endtask

	task automatic stall_burst(input int n);
		logic [31:0] v;
		for (int i = 0; i < n; i++) begin
			v = next_rand();
			@(posedge clk);
			stall <= 1'b1;
			lookup_valid <= v[0];
			lookup_req.pc <= v;
			lookup_req.ghr <= {v[15:0], v[31:16]};
		end
	endtask

	initial begin
		rst = 1'b0;
		stall = 1'b0;
		lookup_valid = 1'b0;
		lookup_req = '0;
		upd_valid = 1'b0;
		upd = '0;
		for (int i = 0; i < (1 << BASE_IDX_W); i++) begin
			base_model[i] = 2'b01;
		end
		repeat (10) @(posedge clk);
		rst <= 1'b1;
		@(negedge clk);
		check_eq("pred_valid", 32'(1'b0), 32'(pred_valid));

		// fresh pairs predict from the weakly not taken base
		repeat (4) begin
			pick_pc(pc);
			new_pair(pc, -1, -1, g);
			lookup_check(pc, g);
		end

		// base training with a new history each time
		pick_pc(pc);
		for (int i = 0; i < 3; i++) begin
			new_pair(pc, -1, -1, g);
			lookup_check(pc, g);
			if (i < 2) begin
				update_last(pc, g, 1'b1);
			end
		end
		check_eq("pred_taken", 32'(1'b1), 32'(pred_taken));

		// base now predicts taken, so not taken allocates 011
		new_pair(pc, -1, -1, g);
		lookup_check(pc, g);
		update_last(pc, g, 1'b0);
		lookup_check(pc, g);
		check_eq("pred_meta.provider", 32'(3'b001), 32'(pred_meta.provider));

		// allocations climb to bank 2, which then walks both ways
		pick_pc(pc);
		new_pair(pc, -1, -1, g);
		lookup_check(pc, g);
		update_last(pc, g, 1'b1);
		lookup_check(pc, g);
		check_eq("pred_meta.provider", 32'(3'b001), 32'(pred_meta.provider));
		update_last(pc, g, 1'b0);
		lookup_check(pc, g);
		update_last(pc, g, 1'b1);
		lookup_check(pc, g);
		check_eq("pred_meta.provider", 32'(3'b100), 32'(pred_meta.provider));
		repeat (5) begin
			update_last(pc, g, 1'b0);
			lookup_check(pc, g);
		end
		repeat (5) begin
			update_last(pc, g, 1'b1);
			lookup_check(pc, g);
		end

		// same bank 0 slot with another tag
		saved_ctr = ent_ctr[0];
		saved_u = ent_u[0];
		new_pair(pc, int'(model_idx(pc, g, 0)), int'(model_tag(pc, g, 0)), g2);
		ent_ctr[0] = saved_ctr;
		ent_u[0] = saved_u;
		lookup_check(pc, g2);
		check_eq("pred_meta.provider", 32'(3'b000), 32'(pred_meta.provider));

		// lookups held off by stall
		r = next_rand();
		@(posedge clk);
		stall <= 1'b1;
		lookup_valid <= 1'b1;
		lookup_req.pc <= r;
		lookup_req.ghr <= ~r;
		repeat (5) @(posedge clk);
		lookup_valid <= 1'b0;
		lookup_check(pc, g2);

		repeat (12) begin
			pick_pc(pc);
			new_pair(pc, -1, -1, g);
			repeat (8) begin
				r = next_rand();
				stall_burst(int'(r[1:0]));
				lookup_check(pc, g);
				update_last(pc, g, r[8]);
			end
		end

		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/tage_top.sv
`timescale 1ns/1ps
`default_nettype none

module tage_top import tage_pkg::*; #(
	parameter int unsigned HIST_LEN [NBANK] = '{8, 16, 32}
) (
	input wire clk,
	input wire rst,
	input wire stall,
	input wire lookup_valid,
	input wire tage_req_t lookup_req,
	input wire upd_valid,
	input wire tage_upd_t upd,
	output logic pred_valid,
	output logic pred_taken,
	output tage_meta_t pred_meta
);

	tidx_t [NBANK-1:0] lk_idx;
	tag_t [NBANK-1:0] lk_tag;
	tidx_t [NBANK-1:0] up_idx;
	tag_t [NBANK-1:0] up_tag;

	bank_mask_t hits;
	ctr_t [NBANK-1:0] ctrs;
	u_t [NBANK-1:0] us;
	bctr_t base_ctr;

	bank_mask_t wr_en;
	tidx_t [NBANK-1:0] wr_idx;
	tag_t [NBANK-1:0] wr_tag;
	ctr_t [NBANK-1:0] wr_ctr;
	bank_mask_t u_wr_en;
	u_t [NBANK-1:0] u_wr;
	logic base_wr_en;
	bctr_t base_wr_ctr;

	for (genvar b = 0; b < NBANK; b++) begin : bank_g
		tage_hash #(.HIST_LEN(HIST_LEN[b]), .BANK(b)) lookup_hash (
			.pc(lookup_req.pc), .ghr(lookup_req.ghr), .idx(lk_idx[b]), .tag(lk_tag[b])
		);
		tage_hash #(.HIST_LEN(HIST_LEN[b]), .BANK(b)) update_hash (
			.pc(upd.req.pc), .ghr(upd.req.ghr), .idx(up_idx[b]), .tag(up_tag[b])
		);
		tage_table table_inst (
			.clk(clk), .rst(rst),
			.rd_en(!stall), .rd_idx(lk_idx[b]), .rd_tag(lk_tag[b]),
			.wr_en(wr_en[b]), .wr_idx(wr_idx[b]), .wr_tag(wr_tag[b]), .wr_ctr(wr_ctr[b]),
			.u_wr_en(u_wr_en[b]), .u_wr(u_wr[b]),
			.hit(hits[b]), .ctr(ctrs[b]), .u(us[b])
		);
	end

	tage_base base_inst (
		.clk(clk), .rst(rst),
		.rd_en(!stall), .rd_pc(lookup_req.pc),
		.wr_en(base_wr_en), .wr_pc(upd.req.pc), .wr_ctr(base_wr_ctr),
		.ctr(base_ctr)
	);

	tage_select select_inst (
		.clk(clk), .rst(rst), .stall(stall), .lookup_valid(lookup_valid),
		.hits(hits), .ctrs(ctrs), .us(us), .base_ctr(base_ctr),
		.pred_valid(pred_valid), .pred_taken(pred_taken), .pred_meta(pred_meta)
	);

	tage_update update_inst (
		.upd_valid(upd_valid), .upd(upd), .upd_idxs(up_idx), .upd_tags(up_tag),
		.wr_en(wr_en), .wr_idx(wr_idx), .wr_tag(wr_tag), .wr_ctr(wr_ctr),
		.u_wr_en(u_wr_en), .u_wr(u_wr),
		.base_wr_en(base_wr_en), .base_wr_ctr(base_wr_ctr)
	);

endmodule

`default_nettype wire

// File: src/tage_update.sv
`timescale 1ns/1ps
`default_nettype none

module tage_update import tage_pkg::*; (
	input wire upd_valid,
	input wire tage_upd_t upd,
	input wire tidx_t [NBANK-1:0] upd_idxs,
	input wire tag_t [NBANK-1:0] upd_tags,
	output bank_mask_t wr_en,
	output tidx_t [NBANK-1:0] wr_idx,
	output tag_t [NBANK-1:0] wr_tag,
	output ctr_t [NBANK-1:0] wr_ctr,
	output bank_mask_t u_wr_en,
	output u_t [NBANK-1:0] u_wr,
	output logic base_wr_en,
	output bctr_t base_wr_ctr
);

	localparam int unsigned STEP_W = 4;
	localparam logic [STEP_W-1:0] CTR_MAX = STEP_W'((1 << CTR_W) - 1);
	localparam logic [STEP_W-1:0] U_MAX = STEP_W'((1 << U_W) - 1);
	localparam logic [STEP_W-1:0] BCTR_MAX = STEP_W'(3);
	localparam ctr_t CTR_WEAK_T = ctr_t'(1 << (CTR_W - 1));
	localparam ctr_t CTR_WEAK_NT = CTR_WEAK_T - ctr_t'(1);

	bank_mask_t provider;
	bank_mask_t above;
	bank_mask_t cand;
	bank_mask_t alloc;
	logic has_prov;
	logic correct;
	logic alloc_fail;

	function automatic logic [STEP_W-1:0] sat_step(input logic [STEP_W-1:0] val,
		input logic up, input logic [STEP_W-1:0] max);
		logic [STEP_W-1:0] res;
		res = val;
		if (up && val != max) begin
			res = val + 1'b1;
		end else if (!up && val != '0) begin
			res = val - 1'b1;
		end
		return res;
	endfunction

	always_comb begin
		provider = upd.meta.provider;
		has_prov = |provider;
		correct = upd.meta.pred_taken == upd.taken;
		// banks with longer history than the provider
		for (int b = 0; b < NBANK; b++) begin
			above[b] = !has_prov;
			for (int j = 0; j < b; j++) begin
				if (provider[j]) begin
					above[b] = 1'b1;
				end
			end
			cand[b] = above[b] && (upd.meta.us[b] == '0);
		end
		// lowest qualifying bank takes the new entry
		for (int b = 0; b < NBANK; b++) begin
			alloc[b] = upd_valid && !correct && cand[b] &&
				((cand & bank_mask_t'((1 << b) - 1)) == '0);
		end
		alloc_fail = upd_valid && !correct && (cand == '0);
	end

	always_comb begin
		for (int b = 0; b < NBANK; b++) begin
			wr_en[b] = upd_valid && (provider[b] || alloc[b]);
			wr_idx[b] = upd_idxs[b];
			wr_tag[b] = upd_tags[b];
			if (alloc[b]) begin
				wr_ctr[b] = upd.taken ? CTR_WEAK_T : CTR_WEAK_NT;
			end else begin
				wr_ctr[b] = ctr_t'(sat_step(STEP_W'(upd.meta.ctrs[b]), upd.taken, CTR_MAX));
			end
			u_wr_en[b] = 1'b0;
			u_wr[b] = upd.meta.us[b];
			if (alloc[b]) begin
				u_wr_en[b] = 1'b1;
				u_wr[b] = '0;
			end else if (upd_valid && provider[b] &&
				upd.meta.pred_taken != upd.meta.alt_taken) begin
				u_wr_en[b] = 1'b1;
				u_wr[b] = u_t'(sat_step(STEP_W'(upd.meta.us[b]), correct, U_MAX));
			end else if (alloc_fail && above[b]) begin
				u_wr_en[b] = 1'b1;
				u_wr[b] = u_t'(sat_step(STEP_W'(upd.meta.us[b]), 1'b0, U_MAX));
			end
		end
	end

	assign base_wr_en = upd_valid && !has_prov;
	assign base_wr_ctr = bctr_t'(sat_step(STEP_W'(upd.meta.base_ctr), upd.taken, BCTR_MAX));

	always_comb begin
		if (upd_valid) begin
			a_one_alloc: assert final ($onehot0(alloc) && (alloc & provider) == '0)
				else $error("tage_update: bad allocation mask %b", alloc);
		end
	end

endmodule

`default_nettype wire

// File: src/tage_select.sv
`timescale 1ns/1ps
`default_nettype none

module tage_select import tage_pkg::*; (
	input wire clk,
	input wire rst,
	input wire stall,
	input wire lookup_valid,
	input wire bank_mask_t hits,
	input wire ctr_t [NBANK-1:0] ctrs,
	input wire u_t [NBANK-1:0] us,
	input wire bctr_t base_ctr,
	output logic pred_valid,
	output logic pred_taken,
	output tage_meta_t pred_meta
);

	bank_mask_t provider;
	ctr_t prov_ctr;
	logic alt_taken;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pred_valid <= 1'b0;
		end else begin
			pred_valid <= lookup_valid && !stall;
		end
	end

	// highest hitting bank provides
	always_comb begin
		provider = '0;
		prov_ctr = '0;
		for (int b = 0; b < NBANK; b++) begin
			provider[b] = hits[b] && ((hits >> (b + 1)) == '0);
			if (provider[b]) begin
				prov_ctr |= ctrs[b];
			end
		end
	end

	assign alt_taken = base_ctr[1];
	assign pred_taken = (|hits) ? prov_ctr[CTR_W-1] : alt_taken;

	// table read data holds under stall, so these do too
	assign pred_meta.provider = provider;
	assign pred_meta.ctrs = ctrs;
	assign pred_meta.us = us;
	assign pred_meta.base_ctr = base_ctr;
	assign pred_meta.alt_taken = alt_taken;
	assign pred_meta.pred_taken = pred_taken;

	a_provider_onehot: assert property (@(posedge clk) disable iff (!rst)
		pred_valid |-> $onehot0(pred_meta.provider))
		else $error("tage_select: provider not one-hot");

endmodule

`default_nettype wire

// File: src/tage_base.sv
`timescale 1ns/1ps
`default_nettype none

module tage_base import tage_pkg::*; (
	input wire clk,
	input wire rst,
	input wire rd_en,
	input wire pc_t rd_pc,
	input wire wr_en,
	input wire pc_t wr_pc,
	input wire bctr_t wr_ctr,
	output bctr_t ctr
);

	localparam int unsigned DEPTH = 1 << BASE_IDX_W;
	localparam bctr_t WEAK_NT = 2'b01;

	bctr_t ctr_mem [DEPTH];
	bidx_t rd_idx;
	bidx_t wr_idx;

	function automatic bidx_t base_index(input pc_t pc);
		return pc[BASE_IDX_W+1:2] ^ pc[PC_W-1:PC_W-BASE_IDX_W];
	endfunction

	assign rd_idx = base_index(rd_pc);
	assign wr_idx = base_index(wr_pc);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				ctr_mem[i] <= WEAK_NT;
			end
			ctr <= WEAK_NT;
		end else begin
			if (rd_en) begin
				ctr <= ctr_mem[rd_idx];
			end
			if (wr_en) begin
				ctr_mem[wr_idx] <= wr_ctr;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/tage_table.sv
`timescale 1ns/1ps
`default_nettype none

module tage_table import tage_pkg::*; (
	input wire clk,
	input wire rst,
	input wire rd_en,
	input wire tidx_t rd_idx,
	input wire tag_t rd_tag,
	input wire wr_en,
	input wire tidx_t wr_idx,
	input wire tag_t wr_tag,
	input wire ctr_t wr_ctr,
	input wire u_wr_en,
	input wire u_t u_wr,
	output logic hit,
	output ctr_t ctr,
	output u_t u
);

	localparam int unsigned DEPTH = 1 << IDX_W;

	tag_t tag_mem [DEPTH];
	ctr_t ctr_mem [DEPTH];
	u_t u_mem [DEPTH];

	tag_t tag_q;
	tag_t rd_tag_q;
	logic primed;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				tag_mem[i] <= '0;
				ctr_mem[i] <= '0;
				u_mem[i] <= '0;
			end
			tag_q <= '0;
			rd_tag_q <= '0;
			ctr <= '0;
			u <= '0;
			primed <= 1'b0;
		end else begin
			// old data wins on a same-address read and write
			if (rd_en) begin
				tag_q <= tag_mem[rd_idx];
				ctr <= ctr_mem[rd_idx];
				u <= u_mem[rd_idx];
				rd_tag_q <= rd_tag;
				primed <= 1'b1;
			end
			if (wr_en) begin
				tag_mem[wr_idx] <= wr_tag;
				ctr_mem[wr_idx] <= wr_ctr;
			end
			if (u_wr_en) begin
				u_mem[wr_idx] <= u_wr;
			end
		end
	end

	// no hit until a first read has happened
	assign hit = primed && (tag_q == rd_tag_q);

	a_enables_known: assert property (@(posedge clk) disable iff (!rst)
		!$isunknown({rd_en, wr_en, u_wr_en}))
		else $error("tage_table: unknown enable");

endmodule

`default_nettype wire

// File: src/tage_hash.sv
`timescale 1ns/1ps
`default_nettype none

module tage_hash import tage_pkg::*; #(
	parameter int unsigned HIST_LEN = 8,
	parameter int unsigned BANK = 0
) (
	input wire pc_t pc,
	input wire ghr_t ghr,
	output tidx_t idx,
	output tag_t tag
);

	localparam int unsigned IDX_CHUNKS = (HIST_LEN + IDX_W - 1) / IDX_W;
	localparam int unsigned TAG_CHUNKS = (HIST_LEN + TAG_W - 1) / TAG_W;

	logic [IDX_CHUNKS*IDX_W-1:0] hist_for_idx;
	logic [TAG_CHUNKS*TAG_W-1:0] hist_for_tag;
	tidx_t fold_idx;
	tag_t fold_tag;

	// history window, zero padded up to whole chunks
	assign hist_for_idx = (IDX_CHUNKS*IDX_W)'(ghr[HIST_LEN-1:0]);
	assign hist_for_tag = (TAG_CHUNKS*TAG_W)'(ghr[HIST_LEN-1:0]);

	always_comb begin
		fold_idx = '0;
		for (int i = 0; i < IDX_CHUNKS; i++) begin
			fold_idx ^= hist_for_idx[i*IDX_W +: IDX_W];
		end
		fold_tag = '0;
		for (int i = 0; i < TAG_CHUNKS; i++) begin
			fold_tag ^= hist_for_tag[i*TAG_W +: TAG_W];
		end
	end

	// bank number mixed in so banks spread differently
	assign idx = fold_idx ^ pc[IDX_W+1:2] ^ tidx_t'(BANK);
	assign tag = fold_tag ^ pc[TAG_W+1:2] ^ pc[2*TAG_W+1:TAG_W+2];

endmodule

`default_nettype wire

// File: src/tage_pkg.sv
`default_nettype none

package tage_pkg;

	localparam int unsigned PC_W = 32;
	localparam int unsigned GHR_W = 32;
	localparam int unsigned NBANK = 3;
	localparam int unsigned IDX_W = 7;
	localparam int unsigned TAG_W = 8;
	localparam int unsigned CTR_W = 3;
	localparam int unsigned U_W = 2;
	localparam int unsigned BASE_IDX_W = 8;

	typedef logic [PC_W-1:0] pc_t;
	typedef logic [GHR_W-1:0] ghr_t;
	typedef logic [IDX_W-1:0] tidx_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [CTR_W-1:0] ctr_t;
	typedef logic [U_W-1:0] u_t;
	typedef logic [BASE_IDX_W-1:0] bidx_t;
	typedef logic [1:0] bctr_t;
	typedef logic [NBANK-1:0] bank_mask_t;

	typedef struct packed {
		pc_t pc;
		ghr_t ghr;
	} tage_req_t;

	// provider is one-hot, zero when the base table provides
	typedef struct packed {
		bank_mask_t provider;
		ctr_t [NBANK-1:0] ctrs;
		u_t [NBANK-1:0] us;
		bctr_t base_ctr;
		logic alt_taken;
		logic pred_taken;
	} tage_meta_t;

	typedef struct packed {
		tage_req_t req;
		tage_meta_t meta;
		logic taken;
	} tage_upd_t;

endpackage

`default_nettype wire
